//--- risc_toy.f
+incdir+.
risc_toy_pkg.sv
fetch_unit.sv
reg_file.sv
decode_unit.sv
execute_unit.sv
writeback_unit.sv
risc_toy.sv
tb_clock.sv
tb_risc_toy.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the RISC_TOY testbench with Verilator and runs it.
# The exit status is the simulator's: nonzero when the testbench fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_risc_toy -f risc_toy.f \
    --Mdir obj_dir -o tb_risc_toy
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/tb_risc_toy
status=$?
if [ $status -ne 0 ]; then
    echo "simulation ended with status $status"
    exit $status
fi

echo "simulation ended with status 0"
exit 0

//--- tb_risc_toy.sv
/*
  Testbench for the RISC_TOY core. A random program runs from an
  instruction ROM model against a data RAM model, and every store the
  core makes is compared with an ISA-level reference run of the program.
*/
`timescale 1ns/1ps
`default_nettype none

`include "risc_toy_config.svh"

module tb_risc_toy;

    localparam int ROM_DEPTH = 512;
    localparam int SEGS      = 3;              // each segment ends in a register dump
    localparam int SEG_BODY  = 64;             // random instructions per segment
    localparam int NOP_OP    = 31;             // unkept opcode, runs as a no-op

    logic                 CLK, RSTN, IREQ, DREQ, DRW;
    risc_toy_pkg::waddr_t IADDR, DADDR;
    risc_toy_pkg::word_t  INSTR, DWDATA, DRDATA;

    risc_toy_pkg::word_t  rom [ROM_DEPTH];
    risc_toy_pkg::word_t  dmem [risc_toy_pkg::waddr_t];   // sparse data RAM
    risc_toy_pkg::waddr_t exp_addr_q [$];
    risc_toy_pkg::word_t  exp_data_q [$];
    risc_toy_pkg::waddr_t fetch_addr, rd_addr, next_iaddr;
    logic                 fetch_pend, rd_pend;
    int                   prog_len, exp_total, stores_seen;
    integer               seed;

    tb_clock clk_gen (.CLK(CLK), .RSTN(RSTN));

    risc_toy dut0 (
        .CLK(CLK), .RSTN(RSTN), .IREQ(IREQ), .IADDR(IADDR), .INSTR(INSTR),
        .DREQ(DREQ), .DRW(DRW), .DADDR(DADDR), .DWDATA(DWDATA), .DRDATA(DRDATA)
    );

    ////////////////////////////////////////
    // failure reporting and compares
    ////////////////////////////////////////
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_word(input risc_toy_pkg::word_t got, input risc_toy_pkg::word_t exp,
                              input string what);
        if (got !== exp) begin
            abort_run($sformatf("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_addr(input risc_toy_pkg::waddr_t got, input risc_toy_pkg::waddr_t exp,
                              input string what);
        if (got !== exp) begin
            abort_run($sformatf("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_iaddr(input risc_toy_pkg::waddr_t got, input risc_toy_pkg::waddr_t exp,
                               input string what);
        if (got !== exp) begin
            abort_run($sformatf("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("Fail at %0t ns: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    task automatic check_idle_outputs(input string when);
        check_flag(IREQ, 1'b1, {"IREQ ", when});
        check_iaddr(IADDR, '0, {"IADDR ", when});
        check_flag(DREQ, 1'b0, {"DREQ ", when});
    endtask

    ////////////////////////////////////////
    // helpers shared by models and generator
    ////////////////////////////////////////
    function automatic risc_toy_pkg::word_t fill_word(input risc_toy_pkg::waddr_t a);
        return {a, 2'b00} ^ 32'h6b2d_e591;     // never-written words
    endfunction

    function automatic risc_toy_pkg::word_t rotate_right(input risc_toy_pkg::word_t v,
                                                         input logic [4:0] n);
        risc_toy_pkg::word_t r;
        r = v;
        for (int i = 0; i < n; i++) begin
            r = {r[0], r[31:1]};               // one bit at a time
        end
        return r;
    endfunction

    function automatic risc_toy_pkg::word_t encode(input logic [4:0] op,
                                                   input risc_toy_pkg::ridx_t ra,
                                                   input risc_toy_pkg::ridx_t rb,
                                                   input logic [16:0] low);
        return {op, ra, rb, low};
    endfunction

    function automatic risc_toy_pkg::ridx_t pick_reg();
        if (($random(seed) & 3) != 0) begin
            return risc_toy_pkg::ridx_t'($random(seed) & 7);  // small set, many hazards
        end
        return risc_toy_pkg::ridx_t'($random(seed));
    endfunction

    ////////////////////////////////////////
    // random program
    ////////////////////////////////////////
    function automatic void gen_program();
        int                  pc, kind;
        logic [4:0]          op;
        logic [16:0]         low;
        risc_toy_pkg::ridx_t ra, rb, rc;
        pc = 0;
        for (int a = 0; a < ROM_DEPTH; a++) begin
            rom[a] = encode(5'(NOP_OP), '0, '0, '0);
        end
        for (int s = 0; s < SEGS; s++) begin
            for (int n = 0; n < SEG_BODY; n++) begin
                kind = $unsigned($random(seed)) % 8;
                ra   = pick_reg();
                rb   = pick_reg();
                rc   = pick_reg();
                low  = 17'($random(seed));
                case (kind)
                    0: op = 5'($unsigned($random(seed)) % 4);        // ADDI ANDI ORI MOVI
                    1: begin
                        op         = 5'(4 + $unsigned($random(seed)) % 7); // ADD .. XOR
                        low[16:12] = rc;
                    end
                    2, 3: begin
                        op         = 5'(11 + $unsigned($random(seed)) % 4); // LSR .. ROR
                        low[16:12] = rc;
                        if (($random(seed) & 3) == 0) begin
                            low[4:0] = '0;                           // amount 0
                        end
                    end
                    4, 5: begin
                        op  = (kind == 4) ? 5'(risc_toy_pkg::op_ld) : 5'(risc_toy_pkg::op_st);
                        low = 17'($random(seed) & 32'hff);           // small byte offset
                        if ($random(seed) & 1) begin
                            rb = 5'(`RT_ABS_BASE);
                        end
                    end
                    6: begin
                        // load, then use the loaded value right away
                        rom[pc] = encode(risc_toy_pkg::op_ld, ra, 5'(`RT_ABS_BASE),
                                         17'($random(seed) & 32'hfc));
                        pc++;
                        op = risc_toy_pkg::op_add;
                        rb = ra;
                        ra = pick_reg();
                    end
                    default: begin
                        op = 5'(15 + $unsigned($random(seed)) % 17); // unkept opcodes
                        if (op == risc_toy_pkg::op_ld || op == risc_toy_pkg::op_st) begin
                            op = 5'(NOP_OP);
                        end
                    end
                endcase
                rom[pc] = encode(op, ra, rb, low);
                pc++;
            end
            for (int r = 0; r < `RT_NREG; r++) begin
                rom[pc] = encode(risc_toy_pkg::op_st, risc_toy_pkg::ridx_t'(r),
                                 5'(`RT_ABS_BASE), 17'(32'h1000 + 128 * s + 4 * r));
                pc++;                                                // register dump
            end
        end
        prog_len = pc;
    endfunction

    ////////////////////////////////////////
    // ISA reference, one instruction at a time
    ////////////////////////////////////////
    function automatic void run_reference();
        risc_toy_pkg::word_t  regs [`RT_NREG];
        risc_toy_pkg::word_t  ram [risc_toy_pkg::waddr_t];
        risc_toy_pkg::word_t  w, imm, b, c, res, ea;
        risc_toy_pkg::waddr_t wa;
        risc_toy_pkg::ridx_t  ra, rb, rc;
        logic [4:0]           amt;
        logic                 wr;
        for (int i = 0; i < `RT_NREG; i++) begin
            regs[i] = '0;
        end
        for (int pc = 0; pc < prog_len; pc++) begin
            w   = rom[pc];
            ra  = w[26:22];
            rb  = w[21:17];
            rc  = w[16:12];
            imm = {{15{w[16]}}, w[16:0]};
            b   = regs[rb];
            c   = regs[rc];
            amt = w[5] ? c[4:0] : w[4:0];
            ea  = ((rb == `RT_ABS_BASE) ? 32'd0 : b) + imm;
            wa  = ea[31:2];
            wr  = 1'b1;
            res = '0;
            case (w[31:27])
                risc_toy_pkg::op_addi: res = b + imm;
                risc_toy_pkg::op_andi: res = b & imm;
                risc_toy_pkg::op_ori:  res = b | imm;
                risc_toy_pkg::op_movi: res = imm;
                risc_toy_pkg::op_add:  res = b + c;
                risc_toy_pkg::op_sub:  res = b - c;
                risc_toy_pkg::op_neg:  res = 32'd0 - c;
                risc_toy_pkg::op_not:  res = ~c;
                risc_toy_pkg::op_and:  res = b & c;
                risc_toy_pkg::op_or:   res = b | c;
                risc_toy_pkg::op_xor:  res = b ^ c;
                risc_toy_pkg::op_lsr:  res = b >> amt;
                risc_toy_pkg::op_asr:  res = (b >> amt) | (b[31] ? ~(32'hffff_ffff >> amt) : 32'd0);
                risc_toy_pkg::op_shl:  res = b << amt;
                risc_toy_pkg::op_ror:  res = rotate_right(b, amt);
                risc_toy_pkg::op_ld:   res = ram.exists(wa) ? ram[wa] : fill_word(wa);
                risc_toy_pkg::op_st: begin
                    wr      = 1'b0;
                    ram[wa] = regs[ra];
                    exp_addr_q.push_back(wa);
                    exp_data_q.push_back(regs[ra]);
                end
                default: wr = 1'b0;                                  // no-op
            endcase
            if (wr) begin
                regs[ra] = res;
            end
        end
    endfunction

    ////////////////////////////////////////
    // memory models
    ////////////////////////////////////////
    always @(posedge CLK) begin
        fetch_pend <= IREQ;
        fetch_addr <= IADDR;
        rd_pend    <= RSTN && DREQ && !DRW;
        rd_addr    <= DADDR;
        if (RSTN && DREQ && DRW) begin
            dmem[DADDR] = DWDATA;                                    // write in the DREQ cycle
        end
    end

    always @(negedge CLK) begin
        if (fetch_pend) begin                                        // else INSTR holds
            INSTR <= (fetch_addr < ROM_DEPTH) ? rom[fetch_addr] : encode(5'(NOP_OP), '0, '0, '0);
        end
        if (rd_pend) begin
            DRDATA <= dmem.exists(rd_addr) ? dmem[rd_addr] : fill_word(rd_addr);
        end
    end

    // fetch order and store compare
    always @(posedge CLK) begin
        if (RSTN) begin
            if (IREQ) begin
                check_iaddr(IADDR, next_iaddr, "IADDR with IREQ high");
                next_iaddr = IADDR + 1'b1;
            end
            if (DREQ && DRW) begin
                if (exp_addr_q.size() == 0) begin
                    abort_run("the DUT made a store that the reference model does not make");
                end else begin
                    check_addr(DADDR, exp_addr_q.pop_front(), "store DADDR");
                    check_word(DWDATA, exp_data_q.pop_front(), "store DWDATA");
                    stores_seen++;
                end
            end
        end
    end

    initial begin
        int waited;
        seed        = 32'h8fa4_8d9a;
        INSTR       = encode(5'(NOP_OP), '0, '0, '0);
        DRDATA      = '0;
        fetch_pend  = 1'b0;
        fetch_addr  = '0;
        rd_pend     = 1'b0;
        rd_addr     = '0;
        next_iaddr  = '0;
        stores_seen = 0;
        gen_program();
        run_reference();
        exp_total = exp_addr_q.size();

        // reset values, and the first cycle after release
        waited = 0;
        while (RSTN !== 1'b1) begin
            @(posedge CLK);
            check_idle_outputs(RSTN ? "after reset" : "in reset");
            waited++;
            if (waited > 40) begin
                abort_run("reset was never released");
            end
        end

        waited = 0;
        while (stores_seen < exp_total) begin
            @(posedge CLK);
            waited++;
            if (waited > 4 * ROM_DEPTH) begin
                abort_run("timed out waiting for the expected stores");
            end
        end
        repeat (30) @(posedge CLK);                                  // catch stray stores

        if (stores_seen == exp_total && exp_addr_q.size() == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            abort_run("store count differs from the reference model");
        end
    end

endmodule

`default_nettype wire

//--- tb_clock.sv
/*
  Clock and reset source for the testbench. 20 ns clock period,
  RSTN held low for the first 10 cycles and released on a falling edge.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic CLK,
    output logic RSTN
);

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;                // 20 ns period
    end

    initial begin
        RSTN = 1'b0;
        repeat (10) @(negedge CLK);            // 10 rising edges in reset
        RSTN = 1'b1;
    end

endmodule

`default_nettype wire

//--- risc_toy.sv
/*
  Top level of the five-stage RISC_TOY core. Instruction and data
  memories are external and attach through the I* and D* ports.
*/
`timescale 1ns/1ps
`default_nettype none

module risc_toy (
    input  logic                 CLK,
    input  logic                 RSTN,
    output logic                 IREQ,
    output risc_toy_pkg::waddr_t IADDR,
    input  risc_toy_pkg::word_t  INSTR,
    output logic                 DREQ,
    output logic                 DRW,
    output risc_toy_pkg::waddr_t DADDR,
    output risc_toy_pkg::word_t  DWDATA,
    input  risc_toy_pkg::word_t  DRDATA
);

    ////////////////////////////////////////
    // stage to stage wires
    ////////////////////////////////////////
    logic                  stall, fetch_valid;
    risc_toy_pkg::ridx_t   rf_ra0, rf_ra1, rf_wa;
    risc_toy_pkg::word_t   rf_rd0, rf_rd1, rf_wd;
    logic                  rf_we;
    logic                  ex_valid, ex_wen;
    risc_toy_pkg::opcode_e ex_op;
    risc_toy_pkg::alu_op_e ex_alu_op;
    risc_toy_pkg::word_t   ex_a, ex_b, ex_imm;
    risc_toy_pkg::ridx_t   ex_dest, mem_dest;
    logic                  mem_wen, mem_is_load;
    risc_toy_pkg::word_t   mem_result;

    fetch_unit u_fetch (
        .CLK(CLK), .RSTN(RSTN), .stall(stall),
        .ireq(IREQ), .iaddr(IADDR), .fetch_valid(fetch_valid)
    );

    decode_unit u_decode (
        .CLK(CLK), .RSTN(RSTN), .instr(INSTR), .fetch_valid(fetch_valid),
        .rf_ra0(rf_ra0), .rf_ra1(rf_ra1), .rf_rd0(rf_rd0), .rf_rd1(rf_rd1),
        .mem_dest(mem_dest), .mem_wen(mem_wen), .stall(stall),
        .ex_valid(ex_valid), .ex_op(ex_op), .ex_alu_op(ex_alu_op),
        .ex_a(ex_a), .ex_b(ex_b), .ex_imm(ex_imm),
        .ex_dest(ex_dest), .ex_wen(ex_wen)
    );

    reg_file u_rf (
        .CLK(CLK), .RSTN(RSTN), .we(rf_we), .wa(rf_wa), .wd(rf_wd),
        .ra0(rf_ra0), .ra1(rf_ra1), .rd0(rf_rd0), .rd1(rf_rd1)
    );

    execute_unit u_execute (
        .CLK(CLK), .RSTN(RSTN), .ex_valid(ex_valid), .ex_op(ex_op),
        .ex_alu_op(ex_alu_op), .ex_a(ex_a), .ex_b(ex_b), .ex_imm(ex_imm),
        .ex_dest(ex_dest), .ex_wen(ex_wen),
        .dreq(DREQ), .drw(DRW), .daddr(DADDR), .dwdata(DWDATA),
        .mem_dest(mem_dest), .mem_wen(mem_wen),
        .mem_result(mem_result), .mem_is_load(mem_is_load)
    );

    writeback_unit u_writeback (
        .CLK(CLK), .RSTN(RSTN), .mem_dest(mem_dest), .mem_wen(mem_wen),
        .mem_result(mem_result), .mem_is_load(mem_is_load), .drdata(DRDATA),
        .rf_we(rf_we), .rf_wa(rf_wa), .rf_wd(rf_wd)
    );

endmodule

`default_nettype wire

//--- writeback_unit.sv
/*
  Writeback stage. Registers the memory stage, picks load data or the
  ALU result and drives the register file write port.
*/
`timescale 1ns/1ps
`default_nettype none

module writeback_unit (
    input  logic                CLK,
    input  logic                RSTN,
    input  risc_toy_pkg::ridx_t mem_dest,
    input  logic                mem_wen,
    input  risc_toy_pkg::word_t mem_result,
    input  logic                mem_is_load,
    input  risc_toy_pkg::word_t drdata,      // valid in the cycle after DREQ
    output logic                rf_we,
    output risc_toy_pkg::ridx_t rf_wa,
    output risc_toy_pkg::word_t rf_wd
);

    risc_toy_pkg::word_t wb_result;
    logic                wb_is_load;

    always_ff @(posedge CLK or negedge RSTN) begin
        if (!RSTN) begin
            rf_we      <= 1'b0;
            rf_wa      <= '0;
            wb_is_load <= 1'b0;
        end else begin
            rf_we      <= mem_wen;
            rf_wa      <= mem_dest;
            wb_is_load <= mem_is_load;
        end
    end

    always_ff @(posedge CLK) begin
        wb_result <= mem_result;
    end

    assign rf_wd = wb_is_load ? drdata : wb_result;  // write lands at end of cycle

endmodule

`default_nettype wire

//--- execute_unit.sv
/*
  Execute stage. ALU with shifter and rotator plus the LD/ST address
  adder; the execute/memory register drives the data memory strobes.
*/
`timescale 1ns/1ps
`default_nettype none

`include "risc_toy_config.svh"

module execute_unit (
    input  logic                  CLK,
    input  logic                  RSTN,
    input  logic                  ex_valid,
    input  risc_toy_pkg::opcode_e ex_op,
    input  risc_toy_pkg::alu_op_e ex_alu_op,
    input  risc_toy_pkg::word_t   ex_a,
    input  risc_toy_pkg::word_t   ex_b,
    input  risc_toy_pkg::word_t   ex_imm,
    input  risc_toy_pkg::ridx_t   ex_dest,
    input  logic                  ex_wen,
    output logic                  dreq,
    output logic                  drw,
    output risc_toy_pkg::waddr_t  daddr,
    output risc_toy_pkg::word_t   dwdata,
    output risc_toy_pkg::ridx_t   mem_dest,
    output logic                  mem_wen,
    output risc_toy_pkg::word_t   mem_result,
    output logic                  mem_is_load
);

    localparam int SHAMT_W = $clog2(`RT_XLEN);

    logic [SHAMT_W-1:0]       shamt;
    logic [2*`RT_XLEN-1:0]    rot_w;       // doubled word for rotate
    risc_toy_pkg::word_t      alu_res, addr;
    logic                     is_ld, is_st;

    assign shamt = ex_b[SHAMT_W-1:0];
    assign rot_w = {ex_a, ex_a} >> shamt;  // amount 0 leaves ex_a
    assign addr  = ex_a + ex_imm;          // base already 0 when absolute
    assign is_ld = (ex_op == risc_toy_pkg::op_ld);
    assign is_st = (ex_op == risc_toy_pkg::op_st);

    ////////////////////////////////////////
    // ALU
    ////////////////////////////////////////
    always_comb begin
        case (ex_alu_op)
            risc_toy_pkg::alu_add:  alu_res = ex_a + ex_b;
            risc_toy_pkg::alu_sub:  alu_res = ex_a - ex_b;
            risc_toy_pkg::alu_and:  alu_res = ex_a & ex_b;
            risc_toy_pkg::alu_or:   alu_res = ex_a | ex_b;
            risc_toy_pkg::alu_xor:  alu_res = ex_a ^ ex_b;
            risc_toy_pkg::alu_neg:  alu_res = -ex_b;            // op on R[rc]
            risc_toy_pkg::alu_not:  alu_res = ~ex_b;
            risc_toy_pkg::alu_pass: alu_res = ex_imm;           // MOVI
            risc_toy_pkg::alu_lsr:  alu_res = ex_a >> shamt;
            risc_toy_pkg::alu_asr:  alu_res = $signed(ex_a) >>> shamt;
            risc_toy_pkg::alu_shl:  alu_res = ex_a << shamt;
            risc_toy_pkg::alu_ror:  alu_res = rot_w[`RT_XLEN-1:0];
            default:                alu_res = ex_a + ex_b;
        endcase
    end

    ////////////////////////////////////////
    // execute/memory register
    ////////////////////////////////////////
    always_ff @(posedge CLK or negedge RSTN) begin
        if (!RSTN) begin
            dreq        <= 1'b0;
            drw         <= 1'b0;
            mem_dest    <= '0;
            mem_wen     <= 1'b0;
            mem_is_load <= 1'b0;
        end else begin
            dreq        <= ex_valid && (is_ld || is_st);  // one cycle per access
            drw         <= ex_valid && is_st;
            mem_dest    <= ex_dest;
            mem_wen     <= ex_valid && ex_wen;
            mem_is_load <= ex_valid && is_ld;
        end
    end

    always_ff @(posedge CLK) begin
        daddr      <= addr[`RT_XLEN-1:2];   // byte to word address
        dwdata     <= ex_b;                 // R[ra] for ST
        mem_result <= alu_res;
    end

    // a store never writes a register
    a_st_no_wen: assert property (@(posedge CLK) disable iff (!RSTN) drw |-> !mem_wen);

endmodule

`default_nettype wire

//--- decode_unit.sv
/*
  Decode stage. Splits the instruction, reads the register file, checks
  read-after-write hazards against execute and memory, and fills the
  decode/execute register or a bubble when stalled.
*/
`timescale 1ns/1ps
`default_nettype none

`include "risc_toy_config.svh"

module decode_unit (
    input  logic                   CLK,
    input  logic                   RSTN,
    input  risc_toy_pkg::word_t    instr,
    input  logic                   fetch_valid,
    output risc_toy_pkg::ridx_t    rf_ra0,
    output risc_toy_pkg::ridx_t    rf_ra1,
    input  risc_toy_pkg::word_t    rf_rd0,
    input  risc_toy_pkg::word_t    rf_rd1,
    input  risc_toy_pkg::ridx_t    mem_dest,
    input  logic                   mem_wen,
    output logic                   stall,
    output logic                   ex_valid,
    output risc_toy_pkg::opcode_e  ex_op,
    output risc_toy_pkg::alu_op_e  ex_alu_op,
    output risc_toy_pkg::word_t    ex_a,
    output risc_toy_pkg::word_t    ex_b,
    output risc_toy_pkg::word_t    ex_imm,
    output risc_toy_pkg::ridx_t    ex_dest,
    output logic                   ex_wen
);

    localparam int SHAMT_W = $clog2(`RT_XLEN);

    logic [4:0]            op_raw;
    risc_toy_pkg::ridx_t   ra, rb, rc;
    risc_toy_pkg::word_t   imm_ext, a_val, b_val;
    risc_toy_pkg::alu_op_e alu_op;
    logic                  kept, wen, use0, use1, is_mem, abs_base;
    logic                  hit0, hit1;

    ////////////////////////////////////////
    // field extraction
    ////////////////////////////////////////
    assign op_raw   = instr[`RT_OP_MSB -: $bits(risc_toy_pkg::opcode_e)];
    assign ra       = instr[`RT_RA_MSB -: `RT_RIDX_W];
    assign rb       = instr[`RT_RB_MSB -: `RT_RIDX_W];
    assign rc       = instr[`RT_RC_MSB -: `RT_RIDX_W];
    assign imm_ext  = {{(`RT_XLEN-`RT_IMM_W){instr[`RT_IMM_W-1]}}, instr[`RT_IMM_W-1:0]};
    assign abs_base = (rb == `RT_ABS_BASE);

    assign rf_ra0 = rb;                                        // base / first operand
    assign rf_ra1 = (op_raw == risc_toy_pkg::op_st) ? ra : rc; // store data or rc

    always_comb begin
        kept   = 1'b1;
        wen    = 1'b1;
        use0   = 1'b0;
        use1   = 1'b0;
        is_mem = 1'b0;
        alu_op = risc_toy_pkg::alu_add;
        b_val  = rf_rd1;
        case (op_raw)
            risc_toy_pkg::op_addi: begin use0 = 1'b1; b_val = imm_ext; end
            risc_toy_pkg::op_andi: begin
                use0   = 1'b1;
                b_val  = imm_ext;
                alu_op = risc_toy_pkg::alu_and;
            end
            risc_toy_pkg::op_ori: begin
                use0   = 1'b1;
                b_val  = imm_ext;
                alu_op = risc_toy_pkg::alu_or;
            end
            risc_toy_pkg::op_movi: alu_op = risc_toy_pkg::alu_pass; // no sources
            risc_toy_pkg::op_add:  begin use0 = 1'b1; use1 = 1'b1; end
            risc_toy_pkg::op_sub:  begin use0 = 1'b1; use1 = 1'b1; alu_op = risc_toy_pkg::alu_sub; end
            risc_toy_pkg::op_and:  begin use0 = 1'b1; use1 = 1'b1; alu_op = risc_toy_pkg::alu_and; end
            risc_toy_pkg::op_or:   begin use0 = 1'b1; use1 = 1'b1; alu_op = risc_toy_pkg::alu_or;  end
            risc_toy_pkg::op_xor:  begin use0 = 1'b1; use1 = 1'b1; alu_op = risc_toy_pkg::alu_xor; end
            risc_toy_pkg::op_neg:  begin use1 = 1'b1; alu_op = risc_toy_pkg::alu_neg; end
            risc_toy_pkg::op_not:  begin use1 = 1'b1; alu_op = risc_toy_pkg::alu_not; end
            risc_toy_pkg::op_lsr, risc_toy_pkg::op_asr,
            risc_toy_pkg::op_shl, risc_toy_pkg::op_ror: begin
                use0 = 1'b1;
                use1 = instr[`RT_SHSEL_BIT];                   // amount from R[rc]
                if (!instr[`RT_SHSEL_BIT]) begin
                    b_val = {{(`RT_XLEN-SHAMT_W){1'b0}}, instr[SHAMT_W-1:0]};
                end
                case (op_raw)
                    risc_toy_pkg::op_lsr: alu_op = risc_toy_pkg::alu_lsr;
                    risc_toy_pkg::op_asr: alu_op = risc_toy_pkg::alu_asr;
                    risc_toy_pkg::op_shl: alu_op = risc_toy_pkg::alu_shl;
                    default:              alu_op = risc_toy_pkg::alu_ror;
                endcase
            end
            risc_toy_pkg::op_ld: begin use0 = ~abs_base; is_mem = 1'b1; end
            risc_toy_pkg::op_st: begin
                use0   = ~abs_base;
                use1   = 1'b1;                                 // store data R[ra]
                is_mem = 1'b1;
                wen    = 1'b0;
            end
            default: begin kept = 1'b0; wen = 1'b0; end        // no-op
        endcase
    end

    assign a_val = (is_mem && abs_base) ? '0 : rf_rd0;        // absolute form

    ////////////////////////////////////////
    // hazard stall, no forwarding
    ////////////////////////////////////////
    assign hit0 = use0 && ((ex_valid && ex_wen && (ex_dest == rb)) ||
                           (mem_wen && (mem_dest == rb)));
    assign hit1 = use1 && ((ex_valid && ex_wen && (ex_dest == rf_ra1)) ||
                           (mem_wen && (mem_dest == rf_ra1)));
    assign stall = fetch_valid && (hit0 || hit1);

    always_ff @(posedge CLK or negedge RSTN) begin
        if (!RSTN) begin
            ex_valid  <= 1'b0;
            ex_wen    <= 1'b0;
            ex_op     <= risc_toy_pkg::op_addi;
            ex_alu_op <= risc_toy_pkg::alu_add;
            ex_dest   <= '0;
        end else if (stall || !fetch_valid) begin
            ex_valid  <= 1'b0;                                 // bubble
            ex_wen    <= 1'b0;
        end else begin
            ex_valid  <= kept;
            ex_wen    <= wen;
            ex_op     <= risc_toy_pkg::opcode_e'(op_raw);
            ex_alu_op <= alu_op;
            ex_dest   <= ra;
        end
    end

    always_ff @(posedge CLK) begin
        ex_a   <= a_val;
        ex_b   <= b_val;
        ex_imm <= imm_ext;                                     // MOVI value, LD/ST offset
    end

    // a hazard clears within two bubbles
    a_stall_len: assert property (@(posedge CLK) disable iff (!RSTN)
        stall ##1 stall |=> !stall);

endmodule

`default_nettype wire

//--- reg_file.sv
/*
  Register file, 32 x 32 bits, two combinational read ports and one
  write port. A read of the register written this cycle sees the new data.
*/
`timescale 1ns/1ps
`default_nettype none

`include "risc_toy_config.svh"

module reg_file (
    input  logic                CLK,
    input  logic                RSTN,
    input  logic                we,
    input  risc_toy_pkg::ridx_t wa,
    input  risc_toy_pkg::word_t wd,
    input  risc_toy_pkg::ridx_t ra0,
    input  risc_toy_pkg::ridx_t ra1,
    output risc_toy_pkg::word_t rd0,
    output risc_toy_pkg::word_t rd1
);

    risc_toy_pkg::word_t regs [`RT_NREG];     // r0 is an ordinary register

    always_ff @(posedge CLK or negedge RSTN) begin
        if (!RSTN) begin
            for (int i = 0; i < `RT_NREG; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wa] <= wd;
        end
    end

    // write-to-read bypass, writeback and decode in the same cycle
    assign rd0 = (we && (wa == ra0)) ? wd : regs[ra0];
    assign rd1 = (we && (wa == ra1)) ? wd : regs[ra1];

endmodule

`default_nettype wire

//--- fetch_unit.sv
/*
  Fetch stage. Keeps the PC as a word address and requests one
  instruction per cycle unless decode stalls.
*/
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
    input  logic                 CLK,
    input  logic                 RSTN,
    input  logic                 stall,        // from decode hazard check
    output logic                 ireq,
    output risc_toy_pkg::waddr_t iaddr,
    output logic                 fetch_valid   // INSTR holds a real instruction
);

    risc_toy_pkg::waddr_t pc;

    assign ireq  = ~stall;                     // memory holds INSTR while low
    assign iaddr = pc;

    always_ff @(posedge CLK or negedge RSTN) begin
        if (!RSTN) begin
            pc          <= '0;
            fetch_valid <= 1'b0;
        end else begin
            if (ireq) begin
                pc <= pc + 1'b1;               // next word
            end
            fetch_valid <= ireq | (fetch_valid & stall); // held instr stays valid
        end
    end

    // a held request always sits on a fetched instruction
    a_hold_valid: assert property (@(posedge CLK) disable iff (!RSTN)
        !ireq |-> fetch_valid);

endmodule

`default_nettype wire

//--- risc_toy_pkg.sv
/*
  Shared types of the RISC_TOY pipeline: data words, addresses,
  register indices, the kept opcodes and the ALU operation codes.
*/
`default_nettype none

`include "risc_toy_config.svh"

package risc_toy_pkg;

    typedef logic [`RT_XLEN-1:0]   word_t;   // register value, instruction, mem data
    typedef logic [`RT_AW-1:0]     waddr_t;  // IADDR / DADDR word address
    typedef logic [`RT_RIDX_W-1:0] ridx_t;   // register number

    // kept opcodes, numbering as in the ISA
    typedef enum logic [4:0] {
        op_addi = 5'd0,
        op_andi = 5'd1,
        op_ori  = 5'd2,
        op_movi = 5'd3,
        op_add  = 5'd4,
        op_sub  = 5'd5,
        op_neg  = 5'd6,
        op_not  = 5'd7,
        op_and  = 5'd8,
        op_or   = 5'd9,
        op_xor  = 5'd10,
        op_lsr  = 5'd11,
        op_asr  = 5'd12,
        op_shl  = 5'd13,
        op_ror  = 5'd14,
        op_ld   = 5'd19,
        op_st   = 5'd21
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_neg,
        alu_not, alu_pass, alu_lsr, alu_asr, alu_shl, alu_ror
    } alu_op_e;

endpackage

`default_nettype wire

//--- risc_toy_config.svh
/*
  Width and instruction-format constants for the RISC_TOY core.
  Included by the package and by any RTL file that slices fields.
*/
`ifndef RISC_TOY_CONFIG_SVH
`define RISC_TOY_CONFIG_SVH

////////////////////////////////////////
// datapath widths
////////////////////////////////////////
`define RT_XLEN      32           // data word width
`define RT_AW        30           // word address width, byte addr [31:2]
`define RT_NREG      32           // general purpose registers
`define RT_RIDX_W    5            // register index width

////////////////////////////////////////
// instruction fields
////////////////////////////////////////
`define RT_OP_MSB    31           // op    [31:27]
`define RT_RA_MSB    26           // ra    [26:22]
`define RT_RB_MSB    21           // rb    [21:17]
`define RT_RC_MSB    16           // rc    [16:12]
`define RT_IMM_W     17           // imm   [16:0], sign extended
`define RT_SHSEL_BIT 5            // shift amount from R[rc] when set

// base field value that selects absolute LD/ST addressing
`define RT_ABS_BASE  31

`endif
